// File: build.f
+incdir+common
common/mem_op_pkg.sv
common/dcache_pkg.sv
dcache/way_hit_check.sv
dcache/dcache_data_array.sv
dcache/store_aligner.sv
dcache/access_control.sv
src/dcache_data_stage.sv
tb/dcache_data_stage_tb.sv

// File: Makefile
# Verilator build and run of the data stage testbench

VERILATOR ?= verilator
TOP ?= dcache_data_stage_tb
FILE_LIST ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All tests passed

SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILE_LIST)) common/dcache_macros.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/dcache_data_stage_tb.sv
/*
 * Data stage testbench
 * Seeded random loads, stores and L2 fills, checked cycle by cycle
 * against a reference model of the tags and the line contents.
 */

`timescale 1ns/10ps

`include "dcache_macros.svh"

module dcache_data_stage_tb;

    import dcache_pkg::*;
    import mem_op_pkg::*;

    localparam int NUM_REQUESTS = 3000;
    localparam tag_t TAG_BASE = 24'h3c5a00;

    logic clk;
    logic reset;
    dcache_req_t req;
    tag_lookup_t tags;
    fill_update_t fill;
    store_req_t store;
    miss_req_t miss;
    lru_update_t lru;
    stage_result_t result;
    line_data_t load_data;

    // Reference copy of the tag stage and of the line storage
    logic model_valid[`DCACHE_SETS][`DCACHE_WAYS];
    tag_t model_tag[`DCACHE_SETS][`DCACHE_WAYS];
    line_data_t model_line[`DCACHE_SETS][`DCACHE_WAYS];

    // Expected registered outputs of the request in flight
    logic exp_valid;
    logic exp_rollback;
    logic exp_suspend;
    logic exp_fault;
    logic exp_is_store;
    logic exp_load_check;
    thread_idx_t exp_thread;
    line_data_t exp_load_data;

    int checks;
    int errors;

    dcache_data_stage i_dcache_data_stage(
        .clk(clk),
        .reset(reset),
        .req(req),
        .tags(tags),
        .fill(fill),
        .store(store),
        .miss(miss),
        .lru(lru),
        .result(result),
        .load_data(load_data));

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [127:0] got,
        input logic [127:0] expected);
        checks++;
        assert (got === expected)
        else
        begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, expected);
        end
    endtask

    function automatic int size_bytes(input mem_size_t size);
        case (size)
            MEM_HALF: return 2;
            MEM_WORD: return 4;
            default: return 1;
        endcase
    endfunction

    function automatic tag_t random_tag();
        return TAG_BASE | tag_t'($urandom % 8);
    endfunction

    // Byte o of the line is mask bit LINE_BYTES-1-o
    function automatic line_mask_t expected_mask(input mem_size_t size,
        input logic [3:0] offset);
        line_mask_t mask;
        int width;
        int first;
        width = size_bytes(size);
        first = int'(offset) - int'(offset) % width;
        mask = '0;
        for (int i = 0; i < width; i++)
            mask[`DCACHE_LINE_BYTES - 1 - first - i] = 1'b1;
        return mask;
    endfunction

    // Most significant value byte lands on the lowest address of each slot
    function automatic line_data_t expected_store_data(input mem_size_t size,
        input logic [31:0] value);
        line_data_t data;
        int width;
        int byte_sel;
        width = size_bytes(size);
        for (int b = 0; b < `DCACHE_LINE_BYTES; b++)
        begin
            byte_sel = width - 1 - b % width;
            data[(`DCACHE_LINE_BYTES - 1 - b) * 8 +: 8] = value[byte_sel * 8 +: 8];
        end
        return data;
    endfunction

    // The fill driven last cycle was written at the edge just passed
    task automatic apply_fill();
        if (fill.tag_en)
        begin
            for (int w = 0; w < `DCACHE_WAYS; w++)
            begin
                if (model_tag[fill.tag_set][w] == fill.tag)
                    model_valid[fill.tag_set][w] = 1'b0;
            end
            model_valid[fill.tag_set][fill.data_way] = 1'b1;
            model_tag[fill.tag_set][fill.data_way] = fill.tag;
        end
        if (fill.data_en)
            model_line[fill.data_set][fill.data_way] = fill.data;
    endtask

    task automatic check_result();
        fault_cause_t cause;
        check_value("result.valid", result.valid, exp_valid);
        check_value("result.rollback", result.rollback, exp_rollback);
        check_value("result.suspend", result.suspend, exp_suspend);
        check_value("result.fault", result.fault, exp_fault);
        if (exp_valid)
            check_value("result.thread", result.thread, exp_thread);
        if (exp_fault)
        begin
            cause = '{valid: 1'b1, is_store: exp_is_store, trap_type: TT_UNALIGNED_ACCESS};
            check_value("result.fault_cause", result.fault_cause, cause);
        end
        if (exp_load_check)
            check_value("load_data", load_data, exp_load_data);
    endtask

    task automatic run_cycle();
        logic valid;
        logic is_load;
        logic hit;
        logic unaligned;
        logic near_miss;
        logic miss_en;
        logic store_en;
        mem_size_t size;
        set_idx_t set_idx;
        tag_t tag;
        logic [3:0] offset;
        way_idx_t pick;
        way_idx_t hit_way;

        valid = ($urandom % 8) != 0;
        is_load = ($urandom % 5) < 3;
        size = mem_size_t'($urandom % 3);
        set_idx = set_idx_t'($urandom);
        offset = 4'($urandom);
        if (($urandom % 4) != 0)
            offset = offset & ~4'(size_bytes(size) - 1);
        pick = way_idx_t'($urandom);
        // Mostly reuse a tag that the model holds, so hits are common
        if (($urandom % 4) != 0 && model_valid[set_idx][pick])
            tag = model_tag[set_idx][pick];
        else
            tag = random_tag();

        fill = '0;
        if (($urandom % 4) == 0)
        begin
            fill.data_en = 1'b1;
            fill.tag_en = 1'b1;
            fill.data_way = way_idx_t'($urandom);
            fill.data_set = set_idx_t'($urandom);
            fill.tag = random_tag();
            // Half the fills land on the requested line
            if (($urandom % 2) == 0)
            begin
                fill.data_set = set_idx;
                fill.tag = tag;
            end
            fill.tag_set = fill.data_set;
            fill.data = {$urandom, $urandom, $urandom, $urandom};
        end

        req.valid = valid;
        req.op.is_load = is_load;
        req.op.size = size;
        req.thread = thread_idx_t'($urandom);
        req.addr.lookup.tag = tag;
        req.addr.lookup.set_idx = set_idx;
        req.addr.lookup.offset = offset;
        req.store_value = $urandom;
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++)
        begin
            tags.valid[w] = model_valid[set_idx][w];
            tags.tag[w] = model_tag[set_idx][w];
            if (model_valid[set_idx][w] && model_tag[set_idx][w] == tag)
            begin
                hit = 1'b1;
                hit_way = way_idx_t'(w);
            end
        end

        unaligned = (size == MEM_HALF && offset[0]) || (size == MEM_WORD && offset[1:0] != 2'b00);
        near_miss = !hit && fill.tag_en && fill.tag_set == set_idx && fill.tag == tag;
        miss_en = valid && is_load && !unaligned && !hit && !near_miss;
        store_en = valid && !is_load && !unaligned;

        #2;
        check_value("lru.en", lru.en, valid && hit && !unaligned);
        if (valid && hit && !unaligned)
            check_value("lru.way", lru.way, hit_way);
        check_value("miss.en", miss.en, miss_en);
        if (miss_en)
        begin
            check_value("miss.line", miss.line, {tag, set_idx});
            check_value("miss.thread", miss.thread, req.thread);
        end
        check_value("store.en", store.en, store_en);
        if (store_en)
        begin
            check_value("store.mask", store.mask, expected_mask(size, offset));
            check_value("store.data", store.data, expected_store_data(size, req.store_value));
            check_value("store.line", store.line, {tag, set_idx});
            check_value("store.thread", store.thread, req.thread);
        end

        exp_valid = valid;
        exp_rollback = valid && is_load && !hit;
        exp_suspend = miss_en;
        exp_fault = valid && unaligned;
        exp_is_store = !is_load;
        exp_thread = req.thread;
        // Load data holds its last value until the next load hit
        if (valid && is_load && hit)
        begin
            exp_load_check = 1'b1;
            if (fill.data_en && fill.data_set == set_idx && fill.data_way == hit_way)
                exp_load_data = fill.data;
            else
                exp_load_data = model_line[set_idx][hit_way];
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, mismatches %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        req = '0;
        tags = '0;
        fill = '0;
        checks = 0;
        errors = 0;
        exp_valid = 1'b0;
        exp_rollback = 1'b0;
        exp_suspend = 1'b0;
        exp_fault = 1'b0;
        exp_is_store = 1'b0;
        exp_load_check = 1'b0;
        exp_thread = '0;
        exp_load_data = '0;
        void'($urandom(32'h9ec9));
        for (int s = 0; s < `DCACHE_SETS; s++)
        begin
            for (int w = 0; w < `DCACHE_WAYS; w++)
            begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w] = '0;
                model_line[s][w] = '0;
            end
        end

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // Result is idle straight out of reset
        check_value("result.valid", result.valid, 1'b0);
        check_value("result.rollback", result.rollback, 1'b0);
        check_value("result.suspend", result.suspend, 1'b0);
        check_value("result.fault", result.fault, 1'b0);
        for (int n = 0; n < NUM_REQUESTS; n++)
        begin
            @(posedge clk);
            #1;
            check_result();
            apply_fill();
            run_cycle();
        end
        @(posedge clk);
        #1;
        check_result();
        finish_run();
    end

endmodule

// File: src/dcache_data_stage.sv
/*
 * L1 data cache data stage
 * Hit check against the fetched tags, line read for loads, store
 * formatting and miss requests toward the L2 interface.
 */

`timescale 1ns/10ps

module dcache_data_stage(
    input logic clk,
    input logic reset,
    input dcache_pkg::dcache_req_t req,
    input dcache_pkg::tag_lookup_t tags,
    input dcache_pkg::fill_update_t fill,
    output dcache_pkg::store_req_t store,
    output dcache_pkg::miss_req_t miss,
    output dcache_pkg::lru_update_t lru,
    output dcache_pkg::stage_result_t result,
    output dcache_pkg::line_data_t load_data);

    import dcache_pkg::*;

    logic way_hit;
    logic near_miss;
    logic read_en;
    way_idx_t hit_way;
    line_mask_t store_mask;
    line_data_t store_data;

    way_hit_check i_way_hit_check(
        .addr(req.addr),
        .tags(tags),
        .fill(fill),
        .way_hit(way_hit),
        .hit_way(hit_way),
        .near_miss(near_miss));

    // Load data comes out registered, one cycle after the request
    dcache_data_array i_dcache_data_array(
        .clk(clk),
        .read_en(read_en),
        .read_way(hit_way),
        .read_set(req.addr.lookup.set_idx),
        .read_data(load_data),
        .fill(fill));

    store_aligner i_store_aligner(
        .op(req.op),
        .offset(req.addr.lookup.offset),
        .store_value(req.store_value),
        .mask(store_mask),
        .data(store_data));

    access_control i_access_control(
        .clk(clk),
        .reset(reset),
        .req(req),
        .way_hit(way_hit),
        .hit_way(hit_way),
        .near_miss(near_miss),
        .store_mask(store_mask),
        .store_data(store_data),
        .read_en(read_en),
        .store(store),
        .miss(miss),
        .lru(lru),
        .result(result));

endmodule

// File: dcache/access_control.sv
/*
 * Data stage access control
 * Decodes the request, checks alignment, drives the store, miss and
 * LRU requests and registers the result toward writeback.
 */

`timescale 1ns/10ps

module access_control(
    input logic clk,
    input logic reset,
    input dcache_pkg::dcache_req_t req,
    input logic way_hit,
    input dcache_pkg::way_idx_t hit_way,
    input logic near_miss,
    input dcache_pkg::line_mask_t store_mask,
    input dcache_pkg::line_data_t store_data,
    output logic read_en,
    output dcache_pkg::store_req_t store,
    output dcache_pkg::miss_req_t miss,
    output dcache_pkg::lru_update_t lru,
    output dcache_pkg::stage_result_t result);

    import dcache_pkg::*;
    import mem_op_pkg::*;

    logic load_en;
    logic store_en;
    logic unaligned;
    logic valid_q;
    logic rollback_q;
    logic suspend_q;
    logic fault_q;
    thread_idx_t thread_q;
    fault_cause_t fault_cause_q;

    assign load_en = req.valid && req.op.is_load;
    assign store_en = req.valid && !req.op.is_load;

    always_comb
    begin
        case (req.op.size)
            MEM_HALF: unaligned = req.addr.lookup.offset[0];
            MEM_WORD: unaligned = |req.addr.lookup.offset[1:0];
            default: unaligned = 1'b0;
        endcase
    end

    assign read_en = load_en && way_hit;

    // Stores go out whether or not the line is present
    assign store.en = store_en && !unaligned;
    assign store.mask = store.en ? store_mask : '0;
    assign store.line = req.addr.line.index;
    assign store.data = store_data;
    assign store.thread = req.thread;

    assign miss.en = load_en && !unaligned && !way_hit && !near_miss;
    assign miss.line = req.addr.line.index;
    assign miss.thread = req.thread;

    assign lru.en = (load_en || store_en) && way_hit && !unaligned;
    assign lru.way = hit_way;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            valid_q <= 1'b0;
            rollback_q <= 1'b0;
            suspend_q <= 1'b0;
            fault_q <= 1'b0;
        end
        else
        begin
            valid_q <= req.valid;
            // A near miss rolls back but leaves the thread running
            rollback_q <= load_en && !way_hit;
            suspend_q <= miss.en;
            fault_q <= req.valid && unaligned;
        end
    end

    always_ff @(posedge clk)
    begin
        thread_q <= req.thread;
        fault_cause_q <= '{valid: 1'b1, is_store: !req.op.is_load,
            trap_type: TT_UNALIGNED_ACCESS};
    end

    always_comb
    begin
        result.valid = valid_q;
        result.thread = thread_q;
        result.rollback = rollback_q;
        result.suspend = suspend_q;
        result.fault = fault_q;
        result.fault_cause = fault_cause_q;
    end

endmodule

// File: dcache/store_aligner.sv
/*
 * Store aligner
 * Builds the byte enables and the big-endian line data for a scalar
 * store. Byte offset o of the line maps to mask bit LINE_BYTES-1-o.
 */

`timescale 1ns/10ps

`include "dcache_macros.svh"

module store_aligner(
    input mem_op_pkg::mem_op_t op,
    input logic [`DCACHE_OFFSET_WIDTH-1:0] offset,
    input logic [31:0] store_value,
    output dcache_pkg::line_mask_t mask,
    output dcache_pkg::line_data_t data);

    import mem_op_pkg::*;

    // Offset bits that must match for a byte to fall inside the access
    logic [`DCACHE_OFFSET_WIDTH-1:0] align_mask;

    always_comb
    begin
        case (op.size)
            MEM_HALF:
            begin
                align_mask = ~`DCACHE_OFFSET_WIDTH'(1);
                data = {(`DCACHE_LINE_WORDS * 2){store_value[15:0]}};
            end

            MEM_WORD:
            begin
                align_mask = ~`DCACHE_OFFSET_WIDTH'(3);
                data = {`DCACHE_LINE_WORDS{store_value}};
            end

            default:
            begin
                align_mask = '1;
                data = {`DCACHE_LINE_BYTES{store_value[7:0]}};
            end
        endcase
    end

    // Lowest address sits in the top byte of the line
    always_comb
    begin
        logic [`DCACHE_OFFSET_WIDTH-1:0] byte_offset;

        mask = '0;
        for (int o = 0; o < `DCACHE_LINE_BYTES; o++)
        begin
            byte_offset = `DCACHE_OFFSET_WIDTH'(o);
            if ((byte_offset & align_mask) == (offset & align_mask))
                mask[`DCACHE_LINE_BYTES - 1 - o] = 1'b1;
        end
    end

endmodule

// File: dcache/dcache_data_array.sv
/*
 * Data cache line storage
 * One registered read port for load hits and one write port for
 * L2 fills. A read of the entry being filled returns the new line.
 */

`timescale 1ns/10ps

`include "dcache_macros.svh"

module dcache_data_array(
    input logic clk,
    input logic read_en,
    input dcache_pkg::way_idx_t read_way,
    input dcache_pkg::set_idx_t read_set,
    output dcache_pkg::line_data_t read_data,
    input dcache_pkg::fill_update_t fill);

    import dcache_pkg::*;

    localparam int DEPTH = `DCACHE_WAYS * `DCACHE_SETS;

    line_data_t lines[DEPTH];
    logic [$clog2(DEPTH)-1:0] read_addr;
    logic [$clog2(DEPTH)-1:0] write_addr;

    // Entry address is way then set
    assign read_addr = {read_way, read_set};
    assign write_addr = {fill.data_way, fill.data_set};

    always_ff @(posedge clk)
    begin
        if (fill.data_en)
            lines[write_addr] <= fill.data;

        // Read data holds between loads
        if (read_en)
        begin
            if (fill.data_en && write_addr == read_addr)
                read_data <= fill.data;
            else
                read_data <= lines[read_addr];
        end
    end

endmodule

// File: dcache/way_hit_check.sv
/*
 * Way hit check
 * Compares the address tag with each valid way, encodes the hit way
 * and flags a miss on a line whose tag is being filled this cycle.
 */

`timescale 1ns/10ps

`include "dcache_macros.svh"

module way_hit_check(
    input dcache_pkg::dcache_addr_t addr,
    input dcache_pkg::tag_lookup_t tags,
    input dcache_pkg::fill_update_t fill,
    output logic way_hit,
    output dcache_pkg::way_idx_t hit_way,
    output logic near_miss);

    import dcache_pkg::*;

    logic [`DCACHE_WAYS-1:0] hit_oh;

    always_comb
    begin
        for (int way = 0; way < `DCACHE_WAYS; way++)
            hit_oh[way] = tags.valid[way] && tags.tag[way] == addr.lookup.tag;
    end

    // A line lives in at most one way, so a plain OR encoder is enough
    always_comb
    begin
        hit_way = '0;
        for (int way = 0; way < `DCACHE_WAYS; way++)
        begin
            if (hit_oh[way])
                hit_way = hit_way | way_idx_t'(way);
        end
    end

    assign way_hit = |hit_oh;

    // Tag arrives too late for this lookup; the thread must retry
    assign near_miss = !way_hit
        && fill.tag_en
        && fill.tag_set == addr.lookup.set_idx
        && fill.tag == addr.lookup.tag;

endmodule

// File: common/dcache_pkg.sv
/*
 * L1 data cache types
 * Geometry types, the physical address views and the port structs
 * of the data stage.
 */

`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_idx_t;
    typedef logic [`DCACHE_SET_WIDTH-1:0] set_idx_t;
    typedef logic [`DCACHE_TAG_WIDTH-1:0] tag_t;
    typedef logic [`DCACHE_TAG_WIDTH+`DCACHE_SET_WIDTH-1:0] line_idx_t;
    typedef logic [`DCACHE_LINE_BYTES*8-1:0] line_data_t;
    typedef logic [`DCACHE_LINE_BYTES-1:0] line_mask_t;
    typedef logic [$clog2(`THREADS_PER_CORE)-1:0] thread_idx_t;

    // Same physical address, seen as a lookup key or as a line number
    typedef union packed
    {
        struct packed
        {
            tag_t tag;
            set_idx_t set_idx;
            logic [`DCACHE_OFFSET_WIDTH-1:0] offset;
        } lookup;
        struct packed
        {
            line_idx_t index;
            logic [`DCACHE_OFFSET_WIDTH-1:0] offset;
        } line;
    } dcache_addr_t;

    typedef struct packed
    {
        logic [`DCACHE_WAYS-1:0] valid;
        tag_t [`DCACHE_WAYS-1:0] tag;
    } tag_lookup_t;

    // L2 fill: data array write plus the matching tag write
    typedef struct packed
    {
        logic data_en;
        way_idx_t data_way;
        set_idx_t data_set;
        line_data_t data;
        logic tag_en;
        set_idx_t tag_set;
        tag_t tag;
    } fill_update_t;

    typedef struct packed
    {
        logic valid;
        mem_op_pkg::mem_op_t op;
        thread_idx_t thread;
        dcache_addr_t addr;
        logic [31:0] store_value;
    } dcache_req_t;

    typedef struct packed
    {
        logic en;
        line_mask_t mask;
        line_idx_t line;
        line_data_t data;
        thread_idx_t thread;
    } store_req_t;

    typedef struct packed
    {
        logic en;
        line_idx_t line;
        thread_idx_t thread;
    } miss_req_t;

    typedef struct packed
    {
        logic en;
        way_idx_t way;
    } lru_update_t;

    typedef struct packed
    {
        logic valid;
        thread_idx_t thread;
        logic rollback;
        logic suspend;
        logic fault;
        mem_op_pkg::fault_cause_t fault_cause;
    } stage_result_t;

endpackage

// File: common/mem_op_pkg.sv
/*
 * Memory operation encoding
 * Access sizes, the load/store operation word and the fault cause
 * reported toward writeback.
 */

package mem_op_pkg;

    typedef enum logic [1:0]
    {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_t;

    typedef struct packed
    {
        logic is_load;
        mem_size_t size;
    } mem_op_t;

    // Trap numbering follows the core's trap table
    typedef enum logic [3:0]
    {
        TT_RESET = 4'd0,
        TT_ILLEGAL_INSTRUCTION = 4'd1,
        TT_PRIVILEGED_OP = 4'd2,
        TT_INTERRUPT = 4'd3,
        TT_SYSCALL = 4'd4,
        TT_UNALIGNED_ACCESS = 4'd5
    } trap_type_t;

    typedef struct packed
    {
        logic valid;
        logic is_store;
        trap_type_t trap_type;
    } fault_cause_t;

endpackage

// File: common/dcache_macros.svh
/*
 * L1 data cache geometry
 * Way and set counts, line size and the address field widths
 * shared by the data stage and its testbench.
 */

`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

`define DCACHE_WAYS 4
`define DCACHE_SETS 16
`define DCACHE_LINE_BYTES 16
`define DCACHE_LINE_WORDS 4

// Physical address split as tag | set | offset
`define DCACHE_OFFSET_WIDTH 4
`define DCACHE_SET_WIDTH 4
`define DCACHE_TAG_WIDTH 24

`define THREADS_PER_CORE 4

`endif
